// ==== rtl/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// address and page geometry
`define ADDR_W      32
`define PFN_W       20
`define PAGE_OFS_W  12

// cache attribute field of config.k0 and the TLB entry
`define CACHE_ATTR_W       3
`define CACHE_ATTR_CACHED  3'd3

// top three address bits of the unmapped kernel segments
`define SEG_KSEG0  3'b100
`define SEG_KSEG1  3'b101

`endif

// ==== rtl/mips_exc_pkg.sv ====
`default_nettype none

package mips_exc_pkg;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13
    } exc_code_e;

    // winning cause of the memory stage
    typedef struct packed {
        logic        exception;
        exc_code_e   code;
        logic [31:0] badvaddr;
    } exc_result_t;

endpackage

`default_nettype wire

// ==== rtl/mem_access_pkg.sv ====
`default_nettype none

`include "mem_config.svh"

package mem_access_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    typedef enum logic [1:0] {
        KIND_PLAIN = 2'b00,
        KIND_LEFT  = 2'b10,   // swl
        KIND_RIGHT = 2'b11    // swr
    } store_kind_e;

    // lookup result of the data-side TLB port
    typedef struct packed {
        logic                      found;
        logic                      valid;
        logic                      dirty;
        logic [`PFN_W-1:0]         pfn;
        logic [`CACHE_ATTR_W-1:0]  cattr;
    } tlb_entry_t;

endpackage

`default_nettype wire

// ==== rtl/xlat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

interface xlat_if
    import mips_exc_pkg::*;
;
    logic [`ADDR_W-1:0] paddr;
    logic               uncached;
    logic               tlb_exc;
    exc_code_e          tlb_code;
    logic               tlb_refill;   // miss, not invalid

    modport src      (output paddr, uncached, tlb_exc, tlb_code, tlb_refill);
    modport exc_sink (input tlb_exc, tlb_code, tlb_refill);
    modport ctl_sink (input uncached);
    modport lane_sink(input paddr);

endinterface

`default_nettype wire

// ==== rtl/addr_translate.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module addr_translate
    import mem_access_pkg::*;
    import mips_exc_pkg::*;
(
    input  wire logic [`ADDR_W-1:0]       vaddr,
    input  wire logic                     access,
    input  wire logic                     is_store,
    input  wire logic                     prior_exc,
    input  wire tlb_entry_t               tlb,
    input  wire logic [`CACHE_ATTR_W-1:0] k0_attr,
    xlat_if.src                           xo
);

    logic mapped;
    logic kseg0;
    logic kseg1;
    logic xlat;
    logic tlb_chk;
    logic tlb_miss;
    logic tlbl;
    logic tlbs;
    logic tlb_mod;

    // kuseg and kseg2/3 go through the TLB
    assign mapped = ~vaddr[`ADDR_W-1] | (vaddr[`ADDR_W-1:`ADDR_W-2] == 2'b11);
    assign kseg0  = (vaddr[`ADDR_W-1:`ADDR_W-3] == `SEG_KSEG0);
    assign kseg1  = (vaddr[`ADDR_W-1:`ADDR_W-3] == `SEG_KSEG1);
    assign xlat   = access & mapped;

    assign xo.paddr = xlat ? {tlb.pfn, vaddr[`PAGE_OFS_W-1:0]}
                           : {3'b000, vaddr[`ADDR_W-4:0]};

    assign xo.uncached = kseg1
                       | (kseg0 & (k0_attr != `CACHE_ATTR_CACHED))
                       | (~kseg0 & ~kseg1 & (tlb.cattr != `CACHE_ATTR_CACHED));

    // earlier stage exception masks the lookup
    assign tlb_chk  = xlat & ~prior_exc;
    assign tlb_miss = ~tlb.found | ~tlb.valid;   // refill or invalid

    assign tlbl    = tlb_chk & tlb_miss & ~is_store;
    assign tlbs    = tlb_chk & tlb_miss & is_store;
    assign tlb_mod = tlb_chk & tlb.found & tlb.valid & ~tlb.dirty & is_store;

    assign xo.tlb_exc    = tlbl | tlbs | tlb_mod;
    assign xo.tlb_refill = tlb_chk & ~tlb.found;

    always_comb begin
        if (tlbl) begin
            xo.tlb_code = EXC_TLBL;
        end else if (tlbs) begin
            xo.tlb_code = EXC_TLBS;
        end else begin
            xo.tlb_code = EXC_MOD;   // don't care unless tlb_exc
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exc_prioritize.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module exc_prioritize
    import mem_access_pkg::*;
    import mips_exc_pkg::*;
(
    input  wire logic [`ADDR_W-1:0] vaddr,
    input  wire logic [`ADDR_W-1:0] pc,
    input  wire logic               access,
    input  wire logic               is_store,
    input  wire logic               is_load,
    input  wire access_size_e       size,
    input  wire store_kind_e        kind,
    input  wire logic               interrupt,
    input  wire logic               overflow,
    input  wire logic               trap,
    input  wire logic               prior_exc,
    input  wire exc_code_e          prior_code,
    xlat_if.exc_sink                xi,
    output logic                    exception,
    output exc_code_e               exc_code,
    output logic [`ADDR_W-1:0]      badvaddr,
    output logic                    tlb_refill
);

    logic        misalign;
    logic        ades;
    logic        adel;
    logic        tlb_win;
    exc_result_t res;

    // swl/swr are exempt, byte never misaligned
    assign misalign = ((size == SIZE_WORD) & (vaddr[1:0] != 2'b00))
                    | ((size == SIZE_HALF) & vaddr[0]);

    assign ades = access & is_store & (kind == KIND_PLAIN) & misalign & ~prior_exc;
    assign adel = access & is_load & (kind == KIND_PLAIN) & misalign & ~prior_exc;

    always_comb begin
        tlb_win = 1'b0;
        if (interrupt) begin
            res = '{exception: 1'b1, code: EXC_INT, badvaddr: '0};
        end else if (overflow && !prior_exc) begin
            res = '{exception: 1'b1, code: EXC_OV, badvaddr: '0};
        end else if (trap && !prior_exc) begin
            res = '{exception: 1'b1, code: EXC_TR, badvaddr: '0};
        end else if (ades) begin
            res = '{exception: 1'b1, code: EXC_ADES, badvaddr: vaddr};
        end else if (adel) begin
            res = '{exception: 1'b1, code: EXC_ADEL, badvaddr: vaddr};
        end else if (xi.tlb_exc && !prior_exc) begin
            res     = '{exception: 1'b1, code: xi.tlb_code, badvaddr: vaddr};
            tlb_win = 1'b1;
        end else begin
            // older address faults always carry the pc
            res = '{exception: prior_exc, code: prior_code, badvaddr: pc};
        end
    end

    assign exception  = res.exception;
    assign exc_code   = res.code;
    assign badvaddr   = res.badvaddr;
    assign tlb_refill = tlb_win & xi.tlb_refill;

endmodule

`default_nettype wire

// ==== rtl/access_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module access_control (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [`ADDR_W-1:0] vaddr,
    input  wire logic               access,
    input  wire logic               is_store,
    input  wire logic               ll,
    input  wire logic               sc,
    input  wire logic               eret_flush,
    input  wire logic               exception,
    xlat_if.ctl_sink                xi,
    output logic                    cache_req,
    output logic                    uncache_req,
    output logic                    wr_en,
    output logic                    sc_result
);

    logic               link_set;
    logic [`ADDR_W-1:0] link_addr;
    logic               sc_ok;
    logic               issue;

    always_ff @(posedge clk) begin
        if (rst || eret_flush || exception) begin
            link_set <= 1'b0;
        end else if (ll) begin
            link_set <= 1'b1;
        end
    end

    // address of the last ll
    always_ff @(posedge clk) begin
        if (ll) begin
            link_addr <= vaddr;
        end
    end

    assign sc_ok = link_set & (link_addr == vaddr) & sc;

    // a failed sc goes nowhere
    assign issue = access & ~exception & ~eret_flush & (~sc | sc_ok);

    assign cache_req   = issue & ~xi.uncached;
    assign uncache_req = issue & xi.uncached;
    assign wr_en       = issue & is_store;
    assign sc_result   = issue;

endmodule

`default_nettype wire

// ==== rtl/store_lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module store_lane_align
    import mem_access_pkg::*;
(
    input  wire logic               wr_en,
    input  wire access_size_e       size,
    input  wire store_kind_e        kind,
    input  wire logic [`ADDR_W-1:0] rt_data,
    xlat_if.lane_sink               xi,
    output logic [3:0]              wstrb,
    output logic [`ADDR_W-1:0]      wdata
);

    logic [1:0] ofs;
    logic [3:0] strb;

    assign ofs = xi.paddr[1:0];

    always_comb begin
        case (kind)
            KIND_LEFT: begin
                strb  = 4'b1111 >> (~ofs);   // 0001 .. 1111
                wdata = rt_data >> {~ofs, 3'b000};
            end
            KIND_RIGHT: begin
                strb  = 4'b1111 << ofs;      // 1111 .. 1000
                wdata = rt_data << {ofs, 3'b000};
            end
            default: begin
                case (size)
                    SIZE_BYTE: begin
                        strb  = 4'b0001 << ofs;
                        wdata = {4{rt_data[7:0]}};
                    end
                    SIZE_HALF: begin
                        strb  = ofs[1] ? 4'b1100 : 4'b0011;
                        wdata = {2{rt_data[15:0]}};
                    end
                    default: begin
                        strb  = 4'b1111;
                        wdata = rt_data;
                    end
                endcase
            end
        endcase
    end

    assign wstrb = wr_en ? strb : 4'b0000;

endmodule

`default_nettype wire

// ==== rtl/mem_access_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_access_prep
    import mem_access_pkg::*;
    import mips_exc_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [`ADDR_W-1:0]       vaddr,
    input  wire logic [`ADDR_W-1:0]       pc,
    input  wire logic                     access,
    input  wire logic                     is_store,
    input  wire logic                     is_load,
    input  wire access_size_e             size,
    input  wire store_kind_e              kind,
    input  wire logic [`ADDR_W-1:0]       rt_data,
    input  wire logic                     ll,
    input  wire logic                     sc,
    input  wire logic                     eret_flush,
    input  wire logic                     interrupt,
    input  wire logic                     overflow,
    input  wire logic                     trap,
    input  wire logic                     prior_exc,
    input  wire exc_code_e                prior_code,
    input  wire tlb_entry_t               tlb,
    input  wire logic [`CACHE_ATTR_W-1:0] k0_attr,
    output logic [`ADDR_W-1:0]            paddr,
    output logic                          cache_req,
    output logic                          uncache_req,
    output logic                          wr_en,
    output logic [3:0]                    wstrb,
    output logic [`ADDR_W-1:0]            wdata,
    output logic                          exception,
    output exc_code_e                     exc_code,
    output logic [`ADDR_W-1:0]            badvaddr,
    output logic                          tlb_refill,
    output logic                          sc_result
);

    xlat_if u_xlat ();

    assign paddr = u_xlat.paddr;

    addr_translate u_translate (
        .vaddr    (vaddr),
        .access   (access),
        .is_store (is_store),
        .prior_exc(prior_exc),
        .tlb      (tlb),
        .k0_attr  (k0_attr),
        .xo       (u_xlat.src)
    );

    exc_prioritize u_exc (
        .vaddr     (vaddr),
        .pc        (pc),
        .access    (access),
        .is_store  (is_store),
        .is_load   (is_load),
        .size      (size),
        .kind      (kind),
        .interrupt (interrupt),
        .overflow  (overflow),
        .trap      (trap),
        .prior_exc (prior_exc),
        .prior_code(prior_code),
        .xi        (u_xlat.exc_sink),
        .exception (exception),
        .exc_code  (exc_code),
        .badvaddr  (badvaddr),
        .tlb_refill(tlb_refill)
    );

    access_control u_ctl (
        .clk        (clk),
        .rst        (rst),
        .vaddr      (vaddr),
        .access     (access),
        .is_store   (is_store),
        .ll         (ll),
        .sc         (sc),
        .eret_flush (eret_flush),
        .exception  (exception),
        .xi         (u_xlat.ctl_sink),
        .cache_req  (cache_req),
        .uncache_req(uncache_req),
        .wr_en      (wr_en),
        .sc_result  (sc_result)
    );

    store_lane_align u_lanes (
        .wr_en  (wr_en),
        .size   (size),
        .kind   (kind),
        .rt_data(rt_data),
        .xi     (u_xlat.lane_sink),
        .wstrb  (wstrb),
        .wdata  (wdata)
    );

endmodule

`default_nettype wire

// ==== verification/mem_access_prep_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_prep_assertions (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       cache_req,
    input wire logic       uncache_req,
    input wire logic       wr_en,
    input wire logic [3:0] wstrb,
    input wire logic       exception,
    input wire logic       sc_result
);

    int fail_count = 0;   // read by the testbench at the end

    req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(cache_req && uncache_req))
        else begin
            fail_count++;
            $error("cache_req and uncache_req high together");
        end

    strobe_gated: assert property (@(posedge clk) disable iff (rst)
        !wr_en |-> (wstrb == 4'b0000))
        else begin
            fail_count++;
            $error("wstrb nonzero while wr_en is low");
        end

    exc_blocks_req: assert property (@(posedge clk) disable iff (rst)
        exception |-> !(cache_req || uncache_req))
        else begin
            fail_count++;
            $error("request issued alongside an exception");
        end

    // link is gone, so no sc may succeed right after reset
    sc_after_reset: assert property (@(posedge clk) rst |=> !sc_result)
        else begin
            fail_count++;
            $error("sc_result high in the cycle after reset");
        end

endmodule

bind mem_access_prep mem_access_prep_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .cache_req  (cache_req),
    .uncache_req(uncache_req),
    .wr_en      (wr_en),
    .wstrb      (wstrb),
    .exception  (exception),
    .sc_result  (sc_result)
);

`default_nettype wire

// ==== verification/tb_mem_access_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module tb_mem_access_prep
    import mem_access_pkg::*;
    import mips_exc_pkg::*;
;
    localparam int NUM_ACCESSES = 2000;
    localparam int WATCHDOG_NS  = (NUM_ACCESSES + 10) * 10 * 2;

    typedef struct packed {
        logic [31:0] paddr;
        logic        cache_req;
        logic        uncache_req;
        logic        wr_en;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        exception;
        logic [4:0]  exc_code;
        logic [31:0] badvaddr;
        logic        tlb_refill;
        logic        sc_result;
    } outputs_t;

    logic clk, rst, access, is_store, is_load, ll, sc, eret_flush;
    logic interrupt, overflow, trap, prior_exc;
    logic [31:0] vaddr, pc, rt_data;
    access_size_e size;
    store_kind_e kind;
    exc_code_e prior_code;
    tlb_entry_t tlb;
    logic [2:0] k0_attr;

    logic [31:0] paddr, wdata, badvaddr;
    logic cache_req, uncache_req, wr_en, exception, tlb_refill, sc_result;
    logic [3:0] wstrb;
    exc_code_e exc_code;

    int error_count = 0;
    int check_count = 0;
    logic checking = 1'b0;
    logic link_set_m = 1'b0;            // testbench copy of the link
    logic [31:0] link_addr_m = '0;
    logic [31:0] last_ll_addr = '0;
    logic prev_ll = 1'b0;
    exc_code_e codes [8] = '{EXC_INT, EXC_MOD, EXC_TLBL, EXC_TLBS,
                             EXC_ADEL, EXC_ADES, EXC_OV, EXC_TR};

    mem_access_prep u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic chance(input int unsigned pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic outputs_t predict(input logic lk_set, input logic [31:0] lk_addr);
        outputs_t o;
        logic mapped, seg0, seg1, unc, tlb_fault, misal, issue;
        logic [4:0] tlb_code;
        logic [1:0] ofs;
        logic [3:0] strb;
        int unsigned shift;
        o = '0;
        mapped = (vaddr[31] == 1'b0) || (vaddr[31:30] == 2'b11);
        seg0 = (vaddr[31:29] == `SEG_KSEG0);
        seg1 = (vaddr[31:29] == `SEG_KSEG1);
        o.paddr = (access && mapped) ? {tlb.pfn, vaddr[11:0]} : {3'b000, vaddr[28:0]};
        if (seg1) unc = 1'b1;
        else if (seg0) unc = (k0_attr != `CACHE_ATTR_CACHED);
        else unc = (tlb.cattr != `CACHE_ATTR_CACHED);
        tlb_fault = 1'b0;
        tlb_code = EXC_MOD;
        if (access && mapped && !prior_exc) begin
            if (!tlb.found || !tlb.valid) begin
                tlb_fault = 1'b1;
                tlb_code = is_store ? EXC_TLBS : EXC_TLBL;
            end else if (is_store && !tlb.dirty) begin
                tlb_fault = 1'b1;
            end
        end
        misal = (size == SIZE_WORD && vaddr[1:0] != 2'b00) || (size == SIZE_HALF && vaddr[0]);
        misal = misal && access && (kind == KIND_PLAIN) && !prior_exc;
        o.exception = 1'b1;
        if (interrupt) begin
            o.exc_code = EXC_INT;
        end else if (prior_exc) begin
            o.exc_code = prior_code;  // passes through with the pc
            o.badvaddr = pc;
        end else if (overflow) begin
            o.exc_code = EXC_OV;
        end else if (trap) begin
            o.exc_code = EXC_TR;
        end else if (misal && is_store) begin
            o.exc_code = EXC_ADES;
            o.badvaddr = vaddr;
        end else if (misal && is_load) begin
            o.exc_code = EXC_ADEL;
            o.badvaddr = vaddr;
        end else if (tlb_fault) begin
            o.exc_code = tlb_code;
            o.badvaddr = vaddr;
            o.tlb_refill = !tlb.found;
        end else begin
            o.exception = 1'b0;
            o.exc_code = prior_code;
            o.badvaddr = pc;
        end
        issue = access && !o.exception && !eret_flush
                && (!sc || (lk_set && lk_addr == vaddr));
        o.cache_req = issue && !unc;
        o.uncache_req = issue && unc;
        o.wr_en = issue && is_store;
        o.sc_result = issue;
        ofs = o.paddr[1:0];
        shift = 8 * (3 - int'(ofs));
        if (kind == KIND_LEFT) begin
            strb = (ofs == 2'd0) ? 4'b0001 : (ofs == 2'd1) ? 4'b0011
                 : (ofs == 2'd2) ? 4'b0111 : 4'b1111;
            o.wdata = rt_data >> shift;
        end else if (kind == KIND_RIGHT) begin
            strb = (ofs == 2'd0) ? 4'b1111 : (ofs == 2'd1) ? 4'b1110
                 : (ofs == 2'd2) ? 4'b1100 : 4'b1000;
            o.wdata = rt_data << (8 * int'(ofs));
        end else if (size == SIZE_BYTE) begin
            strb = 4'b0001 << ofs;
            o.wdata = {4{rt_data[7:0]}};
        end else if (size == SIZE_HALF) begin
            strb = ofs[1] ? 4'b1100 : 4'b0011;
            o.wdata = {2{rt_data[15:0]}};
        end else begin
            strb = 4'b1111;
            o.wdata = rt_data;
        end
        o.wstrb = o.wr_en ? strb : 4'b0000;
        return o;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        error_count++;
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, expected);
    endtask

    task automatic drive_idle();
        access <= 1'b0;
        is_store <= 1'b0;
        is_load <= 1'b0;
        ll <= 1'b0;
        sc <= 1'b0;
        eret_flush <= 1'b0;
        interrupt <= 1'b0;
        overflow <= 1'b0;
        trap <= 1'b0;
        prior_exc <= 1'b0;
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst <= 1'b1;
        drive_idle();
        @(posedge clk);
        rst <= 1'b0;
        vaddr <= last_ll_addr;  // sc to the old link, must fail
        access <= 1'b1;
        is_store <= 1'b1;
        sc <= 1'b1;
        size <= SIZE_WORD;
        kind <= KIND_PLAIN;
        prev_ll = 1'b0;
    endtask

    task automatic drive_random_access();
        logic [31:0] va;
        logic st, do_ll, do_sc;
        tlb_entry_t t;
        va = $urandom;
        case ($urandom_range(7, 0))
            0, 1, 2: va[31] = 1'b0;             // kuseg
            3:       va[31:29] = `SEG_KSEG0;
            4:       va[31:29] = `SEG_KSEG1;
            default: va[31:30] = 2'b11;         // kseg2/3
        endcase
        if (chance(50)) va[1:0] = 2'b00;
        do_sc = (prev_ll && chance(60)) || chance(6);
        do_ll = !do_sc && chance(10);
        st = do_sc || (!do_ll && chance(50));
        if (do_sc && chance(75)) va = last_ll_addr;
        if (do_ll) begin
            va[1:0] = 2'b00;
            last_ll_addr = va;
        end
        prev_ll = do_ll;
        t = '{found: chance(85), valid: chance(85), dirty: chance(80), pfn: 20'($urandom),
              cattr: chance(50) ? `CACHE_ATTR_CACHED : 3'($urandom)};
        @(posedge clk);
        vaddr <= va;
        pc <= $urandom;
        rt_data <= $urandom;
        access <= chance(90);
        is_store <= st;
        is_load <= !st;
        ll <= do_ll;
        sc <= do_sc;
        size <= (do_ll || do_sc) ? SIZE_WORD : access_size_e'($urandom_range(2, 0));
        kind <= (do_ll || do_sc || chance(70)) ? KIND_PLAIN
              : (chance(50) ? KIND_LEFT : KIND_RIGHT);
        eret_flush <= chance(3);
        interrupt <= chance(3);
        overflow <= chance(3);
        trap <= chance(3);
        prior_exc <= chance(5);
        prior_code <= codes[$urandom_range(7, 0)];
        tlb <= t;
        k0_attr <= chance(50) ? `CACHE_ATTR_CACHED : 3'($urandom);
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        outputs_t want;
        want = predict(link_set_m, link_addr_m);
        if (checking) begin
            check_count++;
            assert (paddr === want.paddr) else flag_mismatch("paddr", paddr, want.paddr);
            assert (cache_req === want.cache_req)
                else flag_mismatch("cache_req", cache_req, want.cache_req);
            assert (uncache_req === want.uncache_req)
                else flag_mismatch("uncache_req", uncache_req, want.uncache_req);
            assert (wr_en === want.wr_en) else flag_mismatch("wr_en", wr_en, want.wr_en);
            assert (wstrb === want.wstrb) else flag_mismatch("wstrb", wstrb, want.wstrb);
            assert (wdata === want.wdata) else flag_mismatch("wdata", wdata, want.wdata);
            assert (exception === want.exception)
                else flag_mismatch("exception", exception, want.exception);
            assert (exc_code === want.exc_code)
                else flag_mismatch("exc_code", exc_code, want.exc_code);
            assert (badvaddr === want.badvaddr)
                else flag_mismatch("badvaddr", badvaddr, want.badvaddr);
            assert (tlb_refill === want.tlb_refill)
                else flag_mismatch("tlb_refill", tlb_refill, want.tlb_refill);
            assert (sc_result === want.sc_result)
                else flag_mismatch("sc_result", sc_result, want.sc_result);
        end
        if (rst || eret_flush || want.exception) begin
            link_set_m = 1'b0;
        end else if (ll) begin
            link_set_m = 1'b1;
            link_addr_m = vaddr;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int unsigned seed_dummy;
        int total;
        seed_dummy = $urandom(32'h19e54c33);
        rst = 1'b1;
        {access, is_store, is_load, ll, sc, eret_flush} = '0;
        {interrupt, overflow, trap, prior_exc} = '0;
        vaddr = '0;
        pc = '0;
        rt_data = '0;
        size = SIZE_WORD;
        kind = KIND_PLAIN;
        prior_code = EXC_INT;
        tlb = '0;
        k0_attr = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        checking = 1'b1;
        for (int i = 0; i < NUM_ACCESSES; i++) begin
            if (chance(1)) pulse_reset();
            drive_random_access();
        end
        @(posedge clk);
        drive_idle();
        repeat (2) @(posedge clk);
        total = error_count + u_dut.u_assertions.fail_count;
        $display("checks: %0d, value errors: %0d, assertion failures: %0d",
                 check_count, error_count, u_dut.u_assertions.fail_count);
        if (total == 0 && check_count > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/mips_exc_pkg.sv
rtl/mem_access_pkg.sv
rtl/xlat_if.sv
rtl/addr_translate.sv
rtl/exc_prioritize.sv
rtl/access_control.sv
rtl/store_lane_align.sv
rtl/mem_access_prep.sv
verification/mem_access_prep_assertions.sv
verification/tb_mem_access_prep.sv

// ==== Bender.yml ====
package:
  name: mem_access_prep

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_exc_pkg.sv
      - rtl/mem_access_pkg.sv
      - rtl/xlat_if.sv
      - rtl/addr_translate.sv
      - rtl/exc_prioritize.sv
      - rtl/access_control.sv
      - rtl/store_lane_align.sv
      - rtl/mem_access_prep.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/mem_access_prep_assertions.sv
      - verification/tb_mem_access_prep.sv
